// File: common/router_pkg.sv
package router_pkg;

	// router radix and port numbering
	localparam int port_num = 5;
	localparam int port_idx_width = $clog2(port_num);
	localparam int port_local = 0;
	localparam int port_east = 1;
	localparam int port_north = 2;
	localparam int port_west = 3;
	localparam int port_south = 4;

	// mesh geometry
	localparam int x_node_num = 4;
	localparam int y_node_num = 3;
	localparam int x_addr_width = $clog2(x_node_num);
	localparam int y_addr_width = $clog2(y_node_num);

	// this node sits at x=2, y=1
	localparam int router_x_addr = 2;
	localparam int router_y_addr = 1;

	// input buffering, also the credits each output starts with
	localparam int fifo_depth = 4;
	localparam int fifo_ptr_width = $clog2(fifo_depth);
	localparam int credit_width = $clog2(fifo_depth + 1);

	localparam int payload_width = 32;

	typedef enum logic [1:0] {
		head   = 2'd0,
		body   = 2'd1,
		tail   = 2'd2,
		single = 2'd3
	} flit_kind_t;

	// head and single flits carry {y, x} of the destination in the low payload bits
	typedef struct packed {
		flit_kind_t kind;
		logic [payload_width-1:0] payload;
	} flit_t;

	typedef struct packed {
		logic valid;
		flit_t flit;
	} link_t;

	typedef logic [port_num-1:0] port_vec_t;

endpackage

// File: input_port/flit_fifo.sv
`timescale 1ns/1ns

module flit_fifo (
	input logic clk,
	input logic reset,
	input logic wr,
	input router_pkg::flit_t wr_flit,
	input logic rd,
	output router_pkg::flit_t head,
	output logic not_empty,
	output logic credit
);

	router_pkg::flit_t mem [router_pkg::fifo_depth];
	logic [router_pkg::fifo_ptr_width-1:0] wr_ptr;
	logic [router_pkg::fifo_ptr_width-1:0] rd_ptr;
	logic [router_pkg::credit_width-1:0] count;

	always_ff @(posedge clk) begin
		if (wr)
			mem[wr_ptr] <= wr_flit;
	end

	always_ff @(posedge clk) begin
		if (reset) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
			credit <= 1'b0;
		end else begin
			if (wr)
				wr_ptr <= wr_ptr + 1'b1;
			if (rd)
				rd_ptr <= rd_ptr + 1'b1;
			case ({wr, rd})
				2'b10: count <= count + 1'b1;
				2'b01: count <= count - 1'b1;
				default: count <= count;
			endcase
			// one credit back upstream per popped flit
			credit <= rd;
		end
	end

	assign head = mem[rd_ptr];
	assign not_empty = (count != '0);

	// upstream credit accounting must keep the buffer from overflowing
	assert property (@(posedge clk) disable iff (reset)
		wr |-> (count < router_pkg::fifo_depth));

	// allocator only grants an input that has a flit
	assert property (@(posedge clk) disable iff (reset) rd |-> not_empty);

endmodule

// File: input_port/input_port.sv
`timescale 1ns/1ns

module input_port (
	input logic clk,
	input logic reset,
	input router_pkg::link_t link,
	output logic credit,
	input logic granted,
	output router_pkg::port_vec_t request,
	output router_pkg::flit_t head
);

	logic not_empty;
	logic is_head;
	logic [router_pkg::x_addr_width-1:0] dest_x;
	logic [router_pkg::y_addr_width-1:0] dest_y;
	router_pkg::port_vec_t route_now;
	router_pkg::port_vec_t route_held;

	flit_fifo u_fifo (
		.clk       (clk),
		.reset     (reset),
		.wr        (link.valid),
		.wr_flit   (link.flit),
		.rd        (granted),
		.head      (head),
		.not_empty (not_empty),
		.credit    (credit)
	);

	// destination fields, only meaningful on head and single flits
	assign dest_x = head.payload[router_pkg::x_addr_width-1:0];
	assign dest_y = head.payload[router_pkg::x_addr_width +: router_pkg::y_addr_width];

	assign is_head = (head.kind == router_pkg::head) || (head.kind == router_pkg::single);

	// xy routing, x first then y
	always_comb begin
		route_now = '0;
		if (dest_x > router_pkg::router_x_addr)
			route_now[router_pkg::port_east] = 1'b1;
		else if (dest_x < router_pkg::router_x_addr)
			route_now[router_pkg::port_west] = 1'b1;
		else if (dest_y > router_pkg::router_y_addr)
			route_now[router_pkg::port_north] = 1'b1;
		else if (dest_y < router_pkg::router_y_addr)
			route_now[router_pkg::port_south] = 1'b1;
		else
			route_now[router_pkg::port_local] = 1'b1;
	end

	// body and tail flits follow the route of their head
	always_ff @(posedge clk) begin
		if (reset)
			route_held <= '0;
		else if (granted && head.kind == router_pkg::head)
			route_held <= route_now;
	end

	always_comb begin
		request = '0;
		if (not_empty)
			request = is_head ? route_now : route_held;
	end

endmodule

// File: switch_alloc/rr_arbiter.sv
`timescale 1ns/1ns

module rr_arbiter (
	input logic clk,
	input logic reset,
	input router_pkg::port_vec_t request,
	input logic advance,
	output router_pkg::port_vec_t grant
);

	logic [router_pkg::port_idx_width-1:0] pointer;
	logic [router_pkg::port_idx_width-1:0] winner;
	logic found;

	// first requester at or after the pointer wins
	always_comb begin
		int idx;
		grant = '0;
		winner = '0;
		found = 1'b0;
		for (int i = 0; i < router_pkg::port_num; i++) begin
			idx = (int'(pointer) + i) % router_pkg::port_num;
			if (!found && request[idx]) begin
				grant[idx] = 1'b1;
				winner = idx[router_pkg::port_idx_width-1:0];
				found = 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (reset)
			pointer <= '0;
		else if (advance && found)
			pointer <= (winner == router_pkg::port_num - 1) ? '0 : winner + 1'b1;
	end

	assert property (@(posedge clk) disable iff (reset) $onehot0(grant));

endmodule

// File: switch_alloc/switch_alloc.sv
`timescale 1ns/1ns

module switch_alloc (
	input logic clk,
	input logic reset,
	input router_pkg::port_vec_t request [router_pkg::port_num],
	input router_pkg::flit_kind_t head_kind [router_pkg::port_num],
	input router_pkg::port_vec_t credit_ok,
	output router_pkg::port_vec_t grant [router_pkg::port_num]
);

	// requests seen per output, and grants seen per input
	router_pkg::port_vec_t req_col [router_pkg::port_num];
	router_pkg::port_vec_t in_grant [router_pkg::port_num];

	always_comb begin
		for (int o = 0; o < router_pkg::port_num; o++) begin
			for (int i = 0; i < router_pkg::port_num; i++) begin
				req_col[o][i] = request[i][o];
				in_grant[i][o] = grant[o][i];
			end
		end
	end

	for (genvar o = 0; o < router_pkg::port_num; o++) begin : g_out
		logic locked;
		logic is_head;
		logic is_last;
		router_pkg::port_vec_t lock_owner;
		router_pkg::port_vec_t arb_req;

		// while a packet holds the output only its input may compete
		always_comb begin
			arb_req = locked ? (req_col[o] & lock_owner) : req_col[o];
			if (!credit_ok[o])
				arb_req = '0;
		end

		rr_arbiter u_arb (
			.clk     (clk),
			.reset   (reset),
			.request (arb_req),
			.advance (is_last),
			.grant   (grant[o])
		);

		// kind of the flit that wins this output
		always_comb begin
			is_head = 1'b0;
			is_last = 1'b0;
			for (int i = 0; i < router_pkg::port_num; i++) begin
				if (grant[o][i]) begin
					is_head = (head_kind[i] == router_pkg::head);
					is_last = (head_kind[i] == router_pkg::tail) ||
						(head_kind[i] == router_pkg::single);
				end
			end
		end

		always_ff @(posedge clk) begin
			if (reset) begin
				locked <= 1'b0;
				lock_owner <= '0;
			end else if (is_last) begin
				locked <= 1'b0;
			end else if (is_head) begin
				locked <= 1'b1;
				lock_owner <= grant[o];
			end
		end
	end

	// each input requests a single route, so it wins at most one output
	for (genvar i = 0; i < router_pkg::port_num; i++) begin : g_in_chk
		assert property (@(posedge clk) disable iff (reset) $onehot0(in_grant[i]));
	end

endmodule

// File: rtl/output_port.sv
`timescale 1ns/1ns

module output_port (
	input logic clk,
	input logic reset,
	input router_pkg::port_vec_t grant,
	input router_pkg::flit_t heads [router_pkg::port_num],
	input logic credit_in,
	output router_pkg::link_t link,
	output logic credit_ok
);

	router_pkg::flit_t sel_flit;
	router_pkg::flit_t out_flit;
	logic out_valid;
	logic sent;
	logic [router_pkg::credit_width-1:0] credits;

	// crossbar column, grant is one-hot or zero
	always_comb begin
		sel_flit = '0;
		for (int i = 0; i < router_pkg::port_num; i++) begin
			if (grant[i])
				sel_flit = heads[i];
		end
	end

	assign sent = |grant;

	always_ff @(posedge clk) begin
		if (reset)
			out_valid <= 1'b0;
		else
			out_valid <= sent;
	end

	always_ff @(posedge clk) begin
		if (sent)
			out_flit <= sel_flit;
	end

	assign link = '{valid: out_valid, flit: out_flit};

	// downstream buffer space, a send and a returned credit cancel
	always_ff @(posedge clk) begin
		if (reset)
			credits <= router_pkg::credit_width'(router_pkg::fifo_depth);
		else begin
			case ({sent, credit_in})
				2'b10: credits <= credits - 1'b1;
				2'b01: credits <= credits + 1'b1;
				default: credits <= credits;
			endcase
		end
	end

	assign credit_ok = (credits != '0);

	// downstream never returns more credits than its buffer holds
	assert property (@(posedge clk) disable iff (reset)
		credits <= router_pkg::fifo_depth);

endmodule

// File: rtl/router.sv
`timescale 1ns/1ns

module router (
	input logic clk,
	input logic reset,
	input router_pkg::link_t in_links [router_pkg::port_num],
	output router_pkg::port_vec_t credit_out,
	output router_pkg::link_t out_links [router_pkg::port_num],
	input router_pkg::port_vec_t credit_in
);

	router_pkg::port_vec_t request [router_pkg::port_num];
	router_pkg::flit_t heads [router_pkg::port_num];
	router_pkg::flit_kind_t head_kind [router_pkg::port_num];
	router_pkg::port_vec_t out_grant [router_pkg::port_num];
	router_pkg::port_vec_t in_granted;
	router_pkg::port_vec_t credit_ok;

	// an input is granted when any output picked it
	always_comb begin
		in_granted = '0;
		for (int i = 0; i < router_pkg::port_num; i++) begin
			for (int o = 0; o < router_pkg::port_num; o++)
				in_granted[i] = in_granted[i] | out_grant[o][i];
		end
	end

	for (genvar i = 0; i < router_pkg::port_num; i++) begin : g_port
		input_port u_in (
			.clk     (clk),
			.reset   (reset),
			.link    (in_links[i]),
			.credit  (credit_out[i]),
			.granted (in_granted[i]),
			.request (request[i]),
			.head    (heads[i])
		);

		assign head_kind[i] = heads[i].kind;

		output_port u_out (
			.clk       (clk),
			.reset     (reset),
			.grant     (out_grant[i]),
			.heads     (heads),
			.credit_in (credit_in[i]),
			.link      (out_links[i]),
			.credit_ok (credit_ok[i])
		);
	end

	switch_alloc u_alloc (
		.clk       (clk),
		.reset     (reset),
		.request   (request),
		.head_kind (head_kind),
		.credit_ok (credit_ok),
		.grant     (out_grant)
	);

endmodule

// File: testbench/router_tb.sv
`timescale 1ns/1ns

module router_tb;

	localparam int n = router_pkg::port_num;
	localparam int timeout_cycles = 4000;
	localparam int drain_limit = 1500;

	logic clk = 1'b0;
	logic reset = 1'b1;
	router_pkg::link_t in_links [n] = '{default: '0};
	router_pkg::port_vec_t credit_out;
	router_pkg::link_t out_links [n];
	router_pkg::port_vec_t credit_in = '0;

	// flits waiting at each source, and flits expected per output and input pair
	router_pkg::flit_t src_q [n][$];
	router_pkg::flit_t exp_q [n*n][$];
	int sent_cnt [n] = '{default: 0};
	int credit_cnt [n] = '{default: 0};
	int recv_cnt [n] = '{default: 0};
	int pending [n] = '{default: 0};
	int cur_route [n] = '{default: 0};
	int open_src [n] = '{default: -1};
	logic [n-1:0] hold = '0;
	int cycles = 0;
	int errors = 0;
	int errors_at_start = 0;
	int tests_passed = 0;
	int tests_failed = 0;
	int seq = 0;

	router dut (
		.clk        (clk),
		.reset      (reset),
		.in_links   (in_links),
		.credit_out (credit_out),
		.out_links  (out_links),
		.credit_in  (credit_in)
	);

	always #5 clk = ~clk;

	// xy rule, x first then y
	function automatic int expected_port(int x, int y);
		if (x > router_pkg::router_x_addr)
			return router_pkg::port_east;
		if (x < router_pkg::router_x_addr)
			return router_pkg::port_west;
		if (y > router_pkg::router_y_addr)
			return router_pkg::port_north;
		if (y < router_pkg::router_y_addr)
			return router_pkg::port_south;
		return router_pkg::port_local;
	endfunction

	// source id in bits 30:28, sequence number above the destination
	// body and tail flits carry the inverted destination, which xy-routes elsewhere
	function automatic router_pkg::flit_t make_flit(router_pkg::flit_kind_t kind, int src,
			int x, int y, int num);
		router_pkg::flit_t f;
		logic [3:0] dest;
		dest = {2'(y), 2'(x)};
		if (kind == router_pkg::body || kind == router_pkg::tail)
			dest = ~dest;
		f.kind = kind;
		f.payload = {1'b0, 3'(src), 12'(num), 12'h0, dest};
		return f;
	endfunction

	task automatic queue_packet(int src, int x, int y, int len);
		router_pkg::flit_kind_t kind;
		for (int k = 0; k < len; k++) begin
			if (len == 1)
				kind = router_pkg::single;
			else if (k == 0)
				kind = router_pkg::head;
			else if (k == len - 1)
				kind = router_pkg::tail;
			else
				kind = router_pkg::body;
			src_q[src].push_back(make_flit(kind, src, x, y, seq));
			seq++;
		end
	endtask

	function automatic bit traffic_idle();
		for (int i = 0; i < n * n; i++)
			if (exp_q[i].size() != 0)
				return 1'b0;
		for (int i = 0; i < n; i++)
			if (src_q[i].size() != 0)
				return 1'b0;
		return 1'b1;
	endfunction

	task automatic drain();
		int waited;
		waited = 0;
		while (!traffic_idle() && waited < drain_limit) begin
			@(negedge clk);
			waited++;
		end
		if (!traffic_idle()) begin
			$display("flits still missing after %0d cycles at %0t", waited, $time);
			errors++;
		end
		repeat (8) @(negedge clk);
	endtask

	task automatic check_idle_outputs();
		for (int p = 0; p < n; p++) begin
			if (out_links[p].valid !== 1'b0) begin
				$display("** Error at %0t: out_links[%0d].valid expected 0, actual %b",
					$time, p, out_links[p].valid);
				errors++;
			end
		end
		if (credit_out !== '0) begin
			$display("** Error at %0t: credit_out expected %b, actual %b", $time, 5'b0, credit_out);
			errors++;
		end
	endtask

	task automatic finish_test(string name);
		if (errors == errors_at_start) begin
			tests_passed++;
			$display("test %s: ok", name);
		end else begin
			tests_failed++;
			$display("test %s: %0d errors", name, errors - errors_at_start);
		end
		errors_at_start = errors;
	endtask

	// sources write only while they hold a credit
	always @(posedge clk) begin
		router_pkg::flit_t f;
		for (int i = 0; i < n; i++) begin
			if (!reset && src_q[i].size() > 0 &&
					sent_cnt[i] - credit_cnt[i] < router_pkg::fifo_depth) begin
				f = src_q[i].pop_front();
				if (f.kind == router_pkg::head || f.kind == router_pkg::single)
					cur_route[i] = expected_port(int'(f.payload[1:0]), int'(f.payload[3:2]));
				exp_q[cur_route[i] * n + i].push_back(f);
				sent_cnt[i]++;
				in_links[i] <= '{valid: 1'b1, flit: f};
			end else begin
				in_links[i] <= '0;
			end
		end
	end

	// credit pulses from the dut, and sinks returning credits
	always @(posedge clk) begin
		for (int p = 0; p < n; p++) begin
			if (!reset && credit_out[p])
				credit_cnt[p] <= credit_cnt[p] + 1;
			if (!reset && out_links[p].valid)
				pending[p] = pending[p] + 1;
			if (!reset && !hold[p] && pending[p] > 0) begin
				pending[p] = pending[p] - 1;
				credit_in[p] <= 1'b1;
			end else begin
				credit_in[p] <= 1'b0;
			end
		end
	end

	// compare against the queues and check packets stay whole
	always @(posedge clk) begin
		router_pkg::flit_t got;
		router_pkg::flit_t want;
		int src;
		for (int o = 0; o < n; o++) begin
			if (!reset && out_links[o].valid) begin
				got = out_links[o].flit;
				src = int'(got.payload[30:28]);
				recv_cnt[o]++;
				if (src >= n || exp_q[o * n + src].size() == 0) begin
					$display("flit %h left output %0d with none expected at %0t", got, o, $time);
					errors++;
				end else begin
					want = exp_q[o * n + src].pop_front();
					if (got !== want) begin
						$display("** Error at %0t: out_links[%0d].flit expected %h, actual %h",
							$time, o, want, got);
						errors++;
					end
				end
				if (got.kind == router_pkg::head || got.kind == router_pkg::single) begin
					if (open_src[o] >= 0) begin
						$display("packet from input %0d cut off on output %0d at %0t",
							open_src[o], o, $time);
						errors++;
					end
					open_src[o] = (got.kind == router_pkg::head) ? src : -1;
				end else begin
					if (open_src[o] != src) begin
						$display("flit of input %0d inside another packet on output %0d at %0t",
							src, o, $time);
						errors++;
					end
					if (got.kind == router_pkg::tail)
						open_src[o] = -1;
				end
			end
		end
	end

	always @(posedge clk) begin
		cycles <= cycles + 1;
		if (cycles >= timeout_cycles) begin
			$display("run stopped after %0d cycles without finishing", cycles);
			$display("Simulation failed");
			$finish;
		end
	end

	initial begin
		int start;
		int src;
		int x;
		int y;
		void'($urandom(32'h30b5));

		repeat (16) begin
			@(negedge clk);
			check_idle_outputs();
		end
		@(posedge clk);
		reset <= 1'b0;
		repeat (4) begin
			@(negedge clk);
			check_idle_outputs();
		end
		finish_test("reset state");

		for (int yy = 0; yy < router_pkg::y_node_num; yy++)
			for (int xx = 0; xx < router_pkg::x_node_num; xx++)
				queue_packet(router_pkg::port_local, xx, yy, 1);
		drain();
		finish_test("routing");

		// east and west inputs race for the local output
		queue_packet(router_pkg::port_east, 2, 1, 4);
		queue_packet(router_pkg::port_west, 2, 1, 4);
		drain();
		finish_test("wormhole ordering");

		hold[router_pkg::port_south] = 1'b1;
		start = recv_cnt[router_pkg::port_south];
		for (int k = 0; k < 6; k++)
			queue_packet(router_pkg::port_local, 2, 0, 1);
		repeat (40) @(negedge clk);
		if (recv_cnt[router_pkg::port_south] - start != router_pkg::fifo_depth) begin
			$display("** Error at %0t: out_links[%0d] flit count expected %0d, actual %0d",
				$time, router_pkg::port_south, router_pkg::fifo_depth,
				recv_cnt[router_pkg::port_south] - start);
			errors++;
		end
		hold[router_pkg::port_south] = 1'b0;
		drain();
		if (recv_cnt[router_pkg::port_south] - start != 6) begin
			$display("** Error at %0t: out_links[%0d] flit count expected %0d, actual %0d",
				$time, router_pkg::port_south, 6, recv_cnt[router_pkg::port_south] - start);
			errors++;
		end
		finish_test("back-pressure");

		for (int p = 0; p < 200; p++) begin
			src = int'($urandom_range(n - 1, 0));
			do begin
				x = int'($urandom_range(router_pkg::x_node_num - 1, 0));
				y = int'($urandom_range(router_pkg::y_node_num - 1, 0));
			end while (expected_port(x, y) == src);
			queue_packet(src, x, y, 1 + int'($urandom_range(3, 0)));
		end
		drain();
		finish_test("random traffic");

		for (int i = 0; i < n; i++) begin
			if (credit_cnt[i] != sent_cnt[i]) begin
				$display("** Error at %0t: credit_out[%0d] pulses expected %0d, actual %0d",
					$time, i, sent_cnt[i], credit_cnt[i]);
				errors++;
			end
		end
		finish_test("credit return");

		$display("tests passed: %0d, failed: %0d", tests_passed, tests_failed);
		if (tests_failed == 0 && errors == 0)
			$display("Simulation passed");
		else
			$display("Simulation failed");
		$finish;
	end

endmodule

// File: compile.f
common/router_pkg.sv
input_port/flit_fifo.sv
input_port/input_port.sv
switch_alloc/rr_arbiter.sv
switch_alloc/switch_alloc.sv
rtl/output_port.sv
rtl/router.sv
testbench/router_tb.sv

// File: Makefile
VERILATOR = verilator
VFLAGS = --binary --timing --assert
TOP = router_tb
FILELIST = compile.f
BUILD = obj_dir
LOG = sim.log

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD)
	./$(BUILD)/V$(TOP) > $(LOG) 2>&1 || echo "Simulation failed" >> $(LOG)
	cat $(LOG)
	! grep -q "Simulation failed" $(LOG)

clean:
	rm -rf $(BUILD) $(LOG)
